/* wb_defs.svh */
`ifndef WB_DEFS_SVH
`define WB_DEFS_SVH

// Bus geometry
`define WB_DATA_W 32
`define WB_ADDR_W 32
`define WB_SEL_W (`WB_DATA_W / 8)

// Pipeline stall vector, one bit per stage
`define STALL_W 6

// SRAM slave
`define SRAM_DEPTH 256
`define SRAM_WAIT 2		// Cycles from new strobe to ack

`endif

/* wb_pkg.sv */
`include "wb_defs.svh"

package wb_pkg;

	// Master to slave, one Wishbone classic cycle
	typedef struct packed {
		logic						cyc;
		logic						stb;
		logic						we;
		logic [`WB_SEL_W-1:0]		sel;	// Byte lanes
		logic [`WB_ADDR_W-1:0]		adr;	// Byte address
		logic [`WB_DATA_W-1:0]		dat;	// Write data
	} wb_req_t;

	// Slave to master
	typedef struct packed {
		logic						ack;	// Single-cycle acknowledge
		logic [`WB_DATA_W-1:0]		dat;	// Read data
	} wb_rsp_t;

endpackage

/* cpu_pkg.sv */
`include "wb_defs.svh"

package cpu_pkg;

	// One CPU port access, held until stall clears
	typedef struct packed {
		logic						ce;		// Level chip enable
		logic						we;
		logic [`WB_SEL_W-1:0]		sel;
		logic [`WB_ADDR_W-1:0]		addr;
		logic [`WB_DATA_W-1:0]		wdata;
	} cpu_req_t;

	typedef logic [`STALL_W-1:0] stall_vec_t;

	// Stage positions in the stall vector
	localparam int STALL_PC = 0;
	localparam int STALL_IF = 1;
	localparam int STALL_ID = 2;
	localparam int STALL_EX = 3;
	localparam int STALL_MEM = 4;
	localparam int STALL_WB = 5;

endpackage

/* wb_master_bridge.sv */
`include "wb_defs.svh"

module wb_master_bridge import wb_pkg::*, cpu_pkg::*; (
	input  logic					clk,
	input  logic					rst_n_i,
	input  stall_vec_t				stall_i,		// Pipeline stall vector
	input  logic					flush_i,
	input  cpu_req_t				cpu_req_i,
	output logic [`WB_DATA_W-1:0]	cpu_rdata_o,
	output logic					stallreq_o,
	output wb_req_t					wb_req_o,
	input  wb_rsp_t					wb_rsp_i
);

	typedef enum logic [1:0] {
		IDLE,
		BUSY,
		WAIT_FOR_STALL
	} state_t;

	state_t					state_q;
	wb_req_t				req_q;			// Registered bus request
	logic [`WB_DATA_W-1:0]	rd_buf_q;		// Read data held across a stall
	logic					accept;
	logic					pipe_stalled;

	assign accept = cpu_req_i.ce & ~flush_i;
	assign pipe_stalled = |stall_i;
	assign wb_req_o = req_q;

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state_q <= IDLE;
			req_q <= '0;
			rd_buf_q <= '0;
		end else begin
			case (state_q)
				IDLE: begin
					if (accept) begin
						req_q.cyc <= 1'b1;
						req_q.stb <= 1'b1;
						req_q.we <= cpu_req_i.we;
						req_q.sel <= cpu_req_i.sel;
						req_q.adr <= cpu_req_i.addr;
						req_q.dat <= cpu_req_i.wdata;
						state_q <= BUSY;
					end
				end
				BUSY: begin
					if (wb_rsp_i.ack) begin
						req_q <= '0;		// End of cycle
						rd_buf_q <= req_q.we ? '0 : wb_rsp_i.dat;
						// Other port still holds the pipeline
						state_q <= pipe_stalled ? WAIT_FOR_STALL : IDLE;
					end else if (flush_i) begin
						req_q <= '0;		// Abandon cycle
						rd_buf_q <= '0;
						state_q <= IDLE;
					end
				end
				WAIT_FOR_STALL: begin
					if (!pipe_stalled) begin
						state_q <= IDLE;
					end
				end
				default: begin
					state_q <= IDLE;
				end
			endcase
		end
	end

	// CPU side, combinational on state and ack
	always_comb begin
		stallreq_o = 1'b0;
		cpu_rdata_o = '0;
		case (state_q)
			IDLE: begin
				stallreq_o = accept;		// Stall from the request cycle
			end
			BUSY: begin
				if (wb_rsp_i.ack) begin
					if (!req_q.we) begin
						cpu_rdata_o = wb_rsp_i.dat;	// Bypass on ack
					end
				end else begin
					stallreq_o = 1'b1;
				end
			end
			WAIT_FOR_STALL: begin
				cpu_rdata_o = rd_buf_q;
			end
			default: begin
			end
		endcase
	end

endmodule

/* wb_arbiter.sv */
module wb_arbiter import wb_pkg::*; (
	input  logic		clk,
	input  logic		rst_n_i,
	input  wb_req_t		m0_req_i,		// Load/store
	output wb_rsp_t		m0_rsp_o,
	input  wb_req_t		m1_req_i,		// Fetch
	output wb_rsp_t		m1_rsp_o,
	output wb_req_t		s_req_o,
	input  wb_rsp_t		s_rsp_i
);

	logic grant_q;		// 0 selects m0, 1 selects m1
	logic owner_cyc;
	logic grant;

	assign owner_cyc = grant_q ? m1_req_i.cyc : m0_req_i.cyc;

	// Owner keeps the bus while its cyc is high
	always_comb begin
		grant = grant_q;
		if (!owner_cyc) begin
			if (m0_req_i.cyc) begin
				grant = 1'b0;		// m0 wins ties
			end else if (m1_req_i.cyc) begin
				grant = 1'b1;
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			grant_q <= 1'b0;
		end else begin
			grant_q <= grant;
		end
	end

	assign s_req_o = grant ? m1_req_i : m0_req_i;

	// Response only to the granted master
	always_comb begin
		m0_rsp_o = '0;
		m1_rsp_o = '0;
		if (grant) begin
			m1_rsp_o = s_rsp_i;
		end else begin
			m0_rsp_o = s_rsp_i;
		end
	end

endmodule

/* wb_sram_slave.sv */
`include "wb_defs.svh"

module wb_sram_slave import wb_pkg::*; (
	input  logic		clk,
	input  logic		rst_n_i,
	input  wb_req_t		req_i,
	output wb_rsp_t		rsp_o
);

	localparam int ADDR_LSB = $clog2(`WB_SEL_W);
	localparam int IDX_W = $clog2(`SRAM_DEPTH);
	localparam int CNT_W = $clog2(`SRAM_WAIT + 1);

	logic [`WB_DATA_W-1:0]	mem [`SRAM_DEPTH];
	logic [CNT_W-1:0]		wait_cnt_q;
	logic [IDX_W-1:0]		word_idx;
	logic					active;
	logic					ack;

	assign active = req_i.cyc & req_i.stb;
	assign word_idx = req_i.adr[ADDR_LSB +: IDX_W];		// Wraps at depth
	assign ack = active && (wait_cnt_q == CNT_W'(`SRAM_WAIT));

	// Counter restarts after each ack or when the strobe drops
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			wait_cnt_q <= '0;
		end else if (!active || ack) begin
			wait_cnt_q <= '0;
		end else begin
			wait_cnt_q <= wait_cnt_q + 1'b1;
		end
	end

	// Byte-merged write on the ack cycle
	always_ff @(posedge clk) begin
		if (ack && req_i.we) begin
			for (int i = 0; i < `WB_SEL_W; i++) begin
				if (req_i.sel[i]) begin
					mem[word_idx][8*i +: 8] <= req_i.dat[8*i +: 8];
				end
			end
		end
	end

	assign rsp_o.ack = ack;
	assign rsp_o.dat = ack ? mem[word_idx] : '0;

endmodule

/* stall_ctrl.sv */
module stall_ctrl import cpu_pkg::*; (
	input  logic		rst_n_i,
	input  logic		flush_i,
	input  logic		if_stallreq_i,
	input  logic		mem_stallreq_i,
	output stall_vec_t	stall_o,
	output logic		flush_o
);

	// Later stage request dominates
	always_comb begin
		stall_o = '0;
		if (flush_i) begin
			stall_o = '0;
		end else if (mem_stallreq_i) begin
			stall_o[STALL_MEM:STALL_PC] = '1;		// Writeback keeps running
		end else if (if_stallreq_i) begin
			stall_o[STALL_ID:STALL_PC] = '1;		// Bubble into execute
		end
	end

	assign flush_o = flush_i & rst_n_i;		// No flush while in reset

endmodule

/* wb_subsys_top.sv */
`include "wb_defs.svh"

module wb_subsys_top import wb_pkg::*, cpu_pkg::*; (
	input  logic					clk,
	input  logic					rst_n_i,
	input  logic					flush_i,
	input  cpu_req_t				if_req_i,
	output logic [`WB_DATA_W-1:0]	if_rdata_o,
	input  cpu_req_t				mem_req_i,
	output logic [`WB_DATA_W-1:0]	mem_rdata_o,
	output stall_vec_t				stall_o
);

	wb_req_t		if_wb_req;
	wb_rsp_t		if_wb_rsp;
	wb_req_t		mem_wb_req;
	wb_rsp_t		mem_wb_rsp;
	wb_req_t		s_req;
	wb_rsp_t		s_rsp;
	stall_vec_t		stall;
	logic			flush;
	logic			if_stallreq;
	logic			mem_stallreq;

	assign stall_o = stall;

	wb_master_bridge if_bridge (
		.clk			(clk),
		.rst_n_i		(rst_n_i),
		.stall_i		(stall),
		.flush_i		(flush),
		.cpu_req_i		(if_req_i),
		.cpu_rdata_o	(if_rdata_o),
		.stallreq_o		(if_stallreq),
		.wb_req_o		(if_wb_req),
		.wb_rsp_i		(if_wb_rsp)
	);

	wb_master_bridge mem_bridge (
		.clk			(clk),
		.rst_n_i		(rst_n_i),
		.stall_i		(stall),
		.flush_i		(flush),
		.cpu_req_i		(mem_req_i),
		.cpu_rdata_o	(mem_rdata_o),
		.stallreq_o		(mem_stallreq),
		.wb_req_o		(mem_wb_req),
		.wb_rsp_i		(mem_wb_rsp)
	);

	wb_arbiter arbiter (
		.clk			(clk),
		.rst_n_i		(rst_n_i),
		.m0_req_i		(mem_wb_req),		// Load/store has priority
		.m0_rsp_o		(mem_wb_rsp),
		.m1_req_i		(if_wb_req),
		.m1_rsp_o		(if_wb_rsp),
		.s_req_o		(s_req),
		.s_rsp_i		(s_rsp)
	);

	wb_sram_slave sram (
		.clk			(clk),
		.rst_n_i		(rst_n_i),
		.req_i			(s_req),
		.rsp_o			(s_rsp)
	);

	stall_ctrl stall_ctrl_i (
		.rst_n_i		(rst_n_i),
		.flush_i		(flush_i),
		.if_stallreq_i	(if_stallreq),
		.mem_stallreq_i	(mem_stallreq),
		.stall_o		(stall),
		.flush_o		(flush)
	);

endmodule

/* wb_subsys_assertions.sv */
`include "wb_defs.svh"

module wb_subsys_assertions import wb_pkg::*; #(
	parameter bit CHECK_LATENCY = 1'b0		// Set only on the slave
) (
	input logic		clk,
	input logic		rst_n_i,
	input wb_req_t	req_i,
	input logic		ack_i,
	input logic		stallreq_i,
	input logic		wait_state_i
);

	timeunit 1ns;
	timeprecision 1ps;

	stb_in_cyc: assert property (@(posedge clk) disable iff (!rst_n_i)
		req_i.stb |-> req_i.cyc)
		else $error("stb high outside a bus cycle");

	// Fields hold until ack unless the cycle ends early
	req_stable: assert property (@(posedge clk) disable iff (!rst_n_i)
		(req_i.stb && !ack_i) ##1 req_i.stb |->
			$stable({req_i.we, req_i.sel, req_i.adr, req_i.dat}))
		else $error("request fields changed while waiting for ack");

	if (CHECK_LATENCY) begin : g_latency
		ack_after_wait: assert property (@(posedge clk) disable iff (!rst_n_i)
			(req_i.cyc && req_i.stb) && (!$past(req_i.stb) || $past(ack_i)) |->
				!ack_i [*`SRAM_WAIT] ##1 ack_i)
			else $error("slave ack not at the fixed wait count");
	end else begin : g_stall
		no_stall_in_wait: assert property (@(posedge clk) disable iff (!rst_n_i)
			wait_state_i |-> !stallreq_i)
			else $error("stall request high in WAIT_FOR_STALL");
	end

endmodule

bind wb_master_bridge wb_subsys_assertions #(.CHECK_LATENCY(1'b0)) bridge_checks (
	.clk			(clk),
	.rst_n_i		(rst_n_i),
	.req_i			(wb_req_o),
	.ack_i			(wb_rsp_i.ack),
	.stallreq_i		(stallreq_o),
	.wait_state_i	(state_q == WAIT_FOR_STALL)
);

bind wb_sram_slave wb_subsys_assertions #(.CHECK_LATENCY(1'b1)) sram_checks (
	.clk			(clk),
	.rst_n_i		(rst_n_i),
	.req_i			(req_i),
	.ack_i			(rsp_o.ack),
	.stallreq_i		(1'b0),
	.wait_state_i	(1'b0)
);

/* wb_subsys_tb.sv */
`include "wb_defs.svh"

module wb_subsys_tb import cpu_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int CLK_PERIOD = 40;
	localparam int DRIVE_DLY = 2;
	localparam int TIMEOUT = 50;
	localparam int ACCESS_CYCLES = `SRAM_WAIT + 1;		// Uncontended stall length

	logic					clk;
	logic					rst_n;
	logic					flush;
	cpu_req_t				if_req;
	cpu_req_t				mem_req;
	logic [`WB_DATA_W-1:0]	if_rdata;
	logic [`WB_DATA_W-1:0]	mem_rdata;
	stall_vec_t				stall_vec;

	logic [`WB_DATA_W-1:0]	ref_mem [`SRAM_DEPTH];	// Reference memory model
	logic [`WB_ADDR_W-1:0]	written_q [$];
	int						if_left;				// Stall cycles still due per port
	int						mem_left;
	logic					if_armed;				// Read data due in first idle cycle
	logic					mem_armed;
	logic [`WB_DATA_W-1:0]	if_exp;
	logic [`WB_DATA_W-1:0]	mem_exp;
	int						checks;
	int						errors;
	int						tests;
	int						test_err_base;

	wb_subsys_top wb_subsys_top_i (
		.clk			(clk),
		.rst_n_i		(rst_n),
		.flush_i		(flush),
		.if_req_i		(if_req),
		.if_rdata_o		(if_rdata),
		.mem_req_i		(mem_req),
		.mem_rdata_o	(mem_rdata),
		.stall_o		(stall_vec)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	function automatic void ref_write(input logic [`WB_ADDR_W-1:0] addr,
			input logic [`WB_DATA_W-1:0] data, input logic [`WB_SEL_W-1:0] sel);
		int idx;
		idx = (addr >> 2) % `SRAM_DEPTH;		// Word address wraps at depth
		for (int b = 0; b < `WB_SEL_W; b++) begin
			if (sel[b]) begin
				ref_mem[idx][8*b +: 8] = data[8*b +: 8];
			end
		end
	endfunction

	function automatic logic [`WB_DATA_W-1:0] ref_read(input logic [`WB_ADDR_W-1:0] addr);
		return ref_mem[(addr >> 2) % `SRAM_DEPTH];
	endfunction

	function automatic stall_vec_t stall_expect(input logic flsh, input logic if_busy,
			input logic mem_busy);
		stall_vec_t vec;
		vec = '0;
		if (flsh) begin
			vec = '0;
		end else if (mem_busy) begin
			vec = 6'b01_1111;		// pc through memory
		end else if (if_busy) begin
			vec = 6'b00_0111;		// pc through decode
		end
		return vec;
	endfunction

	function automatic logic [`WB_ADDR_W-1:0] rand_addr();
		return $urandom & 32'hffff_fffc;
	endfunction

	task automatic compare_value(input string name, input logic [`WB_DATA_W-1:0] actual,
			input logic [`WB_DATA_W-1:0] expected);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("** Error at %0d ns: %s = %h, expected %h", $time, name, actual, expected);
		end
	endtask

	task automatic report_test(input string name);
		tests++;
		$display("Test %0d %s: %0d errors", tests, name, errors - test_err_base);
		test_err_base = errors;
	endtask

	task automatic end_run();
		$display("Tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
		if (errors == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	endtask

	task automatic wait_stall_clear();
		int cycles;
		cycles = 0;
		@(negedge clk);
		while (stall_vec !== '0 && cycles < TIMEOUT) begin
			cycles++;
			@(negedge clk);
		end
		if (stall_vec !== '0) begin
			errors++;
			$display("Timeout: stall_o did not return to zero within %0d cycles", TIMEOUT);
			end_run();
		end
	endtask

	task automatic start_access(input logic is_fetch, input logic we,
			input logic [`WB_SEL_W-1:0] sel, input logic [`WB_ADDR_W-1:0] addr,
			input logic [`WB_DATA_W-1:0] wdata, input int stall_cycles);
		cpu_req_t req;
		req = '{ce: 1'b1, we: we, sel: sel, addr: addr, wdata: wdata};
		if (we) begin
			ref_write(addr, wdata, sel);
		end
		if (is_fetch) begin
			if_req = req;
			if_left = stall_cycles;
			if_armed = !we;
			if_exp = ref_read(addr);
		end else begin
			mem_req = req;
			mem_left = stall_cycles;
			mem_armed = !we;
			mem_exp = ref_read(addr);
		end
	endtask

	task automatic finish_access();
		wait_stall_clear();
		@(posedge clk);
		#DRIVE_DLY;
		if_req = '0;
		mem_req = '0;
	endtask

	task automatic single_access(input logic is_fetch, input logic we,
			input logic [`WB_SEL_W-1:0] sel, input logic [`WB_ADDR_W-1:0] addr,
			input logic [`WB_DATA_W-1:0] wdata);
		@(posedge clk);
		#DRIVE_DLY;
		start_access(is_fetch, we, sel, addr, wdata, ACCESS_CYCLES);
		finish_access();
	endtask

	// Checks the stall vector every cycle and read data in the first idle cycle
	always @(negedge clk) begin
		if (rst_n) begin
			compare_value("stall_o", stall_vec, stall_expect(flush, if_left > 0, mem_left > 0));
			if (stall_vec === '0) begin
				if (if_armed) begin
					compare_value("if_rdata_o", if_rdata, if_exp);
					if_armed = 1'b0;
				end
				if (mem_armed) begin
					compare_value("mem_rdata_o", mem_rdata, mem_exp);
					mem_armed = 1'b0;
				end
			end
			if (if_left > 0) begin
				if_left--;
			end
			if (mem_left > 0) begin
				mem_left--;
			end
		end
	end

	initial begin
		logic [`WB_ADDR_W-1:0] addr;
		logic [`WB_ADDR_W-1:0] addr_b;
		void'($urandom(32'hb4d4));
		rst_n = 1'b0;
		flush = 1'b0;
		if_req = '0;
		mem_req = '0;
		if_left = 0;
		mem_left = 0;
		if_armed = 1'b0;
		mem_armed = 1'b0;
		if_exp = '0;
		mem_exp = '0;
		checks = 0;
		errors = 0;
		tests = 0;
		test_err_base = 0;
		repeat (3) @(posedge clk);
		#DRIVE_DLY;
		rst_n = 1'b1;

		@(negedge clk);
		compare_value("stall_o", stall_vec, '0);
		compare_value("if_rdata_o", if_rdata, '0);
		compare_value("mem_rdata_o", mem_rdata, '0);
		report_test("reset values");

		for (int i = 0; i < 4; i++) begin
			addr = rand_addr();
			single_access(1'b0, 1'b1, '1, addr, $urandom);
			single_access(1'b0, 1'b0, '1, addr, '0);
			written_q.push_back(addr);
		end
		report_test("load/store word write and read");

		for (int i = 0; i < 4; i++) begin
			addr = rand_addr();
			single_access(1'b0, 1'b1, '1, addr, $urandom);
			single_access(1'b0, 1'b1, ($urandom % 15) + 1, addr, $urandom);	// Partial bytes
			single_access(1'b0, 1'b0, '1, addr, '0);
			written_q.push_back(addr);
		end
		report_test("byte select writes");

		foreach (written_q[i]) begin
			single_access(1'b1, 1'b0, '1, written_q[i], '0);
		end
		report_test("fetch reads");

		for (int i = 0; i < 3; i++) begin
			addr = rand_addr();
			addr_b = rand_addr();
			single_access(1'b0, 1'b1, '1, addr, $urandom);
			single_access(1'b0, 1'b1, '1, addr_b, $urandom);
			@(posedge clk);
			#DRIVE_DLY;
			// Load/store owns the bus first and fetch queues behind it
			start_access(1'b1, 1'b0, '1, addr, '0, 2 * ACCESS_CYCLES);
			start_access(1'b0, 1'b0, '1, addr_b, '0, ACCESS_CYCLES);
			finish_access();
		end
		report_test("simultaneous fetch and load/store");

		for (int i = 0; i < 3; i++) begin
			addr = written_q[i];
			@(posedge clk);
			#DRIVE_DLY;
			flush = 1'b1;
			mem_req = '{ce: 1'b1, we: 1'b1, sel: '1, addr: addr, wdata: ~ref_read(addr)};
			repeat (3) @(posedge clk);
			#DRIVE_DLY;
			flush = 1'b0;
			mem_req = '0;
			single_access(1'b0, 1'b0, '1, addr, '0);		// Old word expected
		end
		report_test("flushed write");

		end_run();
	end

endmodule

/* wb_subsys_top.f */
+incdir+.
wb_pkg.sv
cpu_pkg.sv
wb_master_bridge.sv
wb_arbiter.sv
wb_sram_slave.sv
stall_ctrl.sv
wb_subsys_top.sv
wb_subsys_assertions.sv
wb_subsys_tb.sv
